// ==== logic/rvPkg.sv ====
package rvPkg;

  localparam int xlen = 32;
  localparam int regAddrW = 5;

  // major opcodes
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;

  // branch conditions
  localparam logic [2:0] fnBeq  = 3'b000;
  localparam logic [2:0] fnBne  = 3'b001;
  localparam logic [2:0] fnBlt  = 3'b100;
  localparam logic [2:0] fnBge  = 3'b101;
  localparam logic [2:0] fnBltu = 3'b110;
  localparam logic [2:0] fnBgeu = 3'b111;

  // load and store widths
  localparam logic [2:0] fnLb  = 3'b000;
  localparam logic [2:0] fnLh  = 3'b001;
  localparam logic [2:0] fnLw  = 3'b010;
  localparam logic [2:0] fnLbu = 3'b100;
  localparam logic [2:0] fnLhu = 3'b101;
  localparam logic [2:0] fnSb  = 3'b000;
  localparam logic [2:0] fnSh  = 3'b001;
  localparam logic [2:0] fnSw  = 3'b010;

  // alu operations, shared by OP and OP-IMM
  localparam logic [2:0] fnAdd  = 3'b000;
  localparam logic [2:0] fnSll  = 3'b001;
  localparam logic [2:0] fnSlt  = 3'b010;
  localparam logic [2:0] fnSltu = 3'b011;
  localparam logic [2:0] fnXor  = 3'b100;
  localparam logic [2:0] fnSr   = 3'b101;
  localparam logic [2:0] fnOr   = 3'b110;
  localparam logic [2:0] fnAnd  = 3'b111;
  localparam logic [2:0] fnJalr = 3'b000;

  // funct7 selects SUB and SRA
  localparam logic [6:0] f7Zero = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000;

  // core sequencing states
  localparam logic [1:0] stFetch   = 2'd0;
  localparam logic [1:0] stExecute = 2'd1;
  localparam logic [1:0] stMemory  = 2'd2;

  typedef enum logic [3:0] {
    Lui, Auipc, Jal, Jalr, Branch, Load, Store, OpImm, Op, Unsupported
  } InstType;

  typedef enum logic [3:0] {
    Add, Sub, And, Or, Xor, Slt, Sltu, Sll, Srl, Sra
  } AluFunc;

  typedef enum logic [2:0] {Eq, Neq, Lt, Ge, Ltu, Geu} BrFunc;

  typedef enum logic [2:0] {Lw, Lh, Lb, Lhu, Lbu, Sw, Sh, Sb} MemFunc;

  typedef struct packed {
    InstType               itype;
    AluFunc                aluFunc;
    BrFunc                 brFunc;
    MemFunc                memFunc;
    logic [regAddrW-1:0]   dst;
    logic                  dstValid;
    logic [regAddrW-1:0]   src1;
    logic [regAddrW-1:0]   src2;
    logic [xlen-1:0]       imm;
  } DecodedInst;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } RFmt;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } IFmt;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } SFmt;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } BFmt;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } UFmt;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } JFmt;

  typedef union packed {
    RFmt rFmt;
    IFmt iFmt;
    SFmt sFmt;
    BFmt bFmt;
    UFmt uFmt;
    JFmt jFmt;
  } InstWord;

endpackage

// ==== logic/regPortIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface regPortIf;
  logic [rvPkg::regAddrW-1:0] rs1Addr;
  logic [rvPkg::regAddrW-1:0] rs2Addr;
  logic [rvPkg::xlen-1:0]     rs1Data;
  logic [rvPkg::xlen-1:0]     rs2Data;
  logic                       wrEn;
  logic [rvPkg::regAddrW-1:0] wrAddr;
  logic [rvPkg::xlen-1:0]     wrData;

  modport core (
    output rs1Addr, rs2Addr, wrEn, wrAddr, wrData,
    input  rs1Data, rs2Data
  );

  modport regFile (
    input  rs1Addr, rs2Addr, wrEn, wrAddr, wrData,
    output rs1Data, rs2Data
  );
endinterface

`default_nettype wire

// ==== logic/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  rvPkg::InstWord    inst,
  output rvPkg::DecodedInst dinst
);
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [rvPkg::xlen-1:0] immI, immS, immB, immU, immJ;

  // opcode, funct3 and funct7 sit at the same bits in every format
  assign opcode = inst.rFmt.opcode;
  assign funct3 = inst.rFmt.funct3;
  assign funct7 = inst.rFmt.funct7;

  // sign-extended immediates, one per format view
  assign immI = {{20{inst.iFmt.imm[11]}}, inst.iFmt.imm};
  assign immS = {{20{inst.sFmt.immHi[6]}}, inst.sFmt.immHi, inst.sFmt.immLo};
  assign immB = {{19{inst.bFmt.imm12}}, inst.bFmt.imm12, inst.bFmt.imm11,
                 inst.bFmt.imm10to5, inst.bFmt.imm4to1, 1'b0};
  assign immU = {inst.uFmt.imm, 12'b0};
  assign immJ = {{11{inst.jFmt.imm20}}, inst.jFmt.imm20, inst.jFmt.imm19to12,
                 inst.jFmt.imm11, inst.jFmt.imm10to1, 1'b0};

  always_comb begin
    dinst = '0;
    dinst.itype = rvPkg::Unsupported;
    dinst.dst = inst.rFmt.rd;
    dinst.src1 = inst.rFmt.rs1;
    dinst.src2 = inst.rFmt.rs2;
    dinst.aluFunc = rvPkg::Add;

    case (opcode)
      rvPkg::opLui: begin
        dinst.itype = rvPkg::Lui;
        dinst.dstValid = 1'b1;
        dinst.imm = immU;
      end
      rvPkg::opAuipc: begin
        dinst.itype = rvPkg::Auipc;
        dinst.dstValid = 1'b1;
        dinst.imm = immU;
      end
      rvPkg::opJal: begin
        dinst.itype = rvPkg::Jal;
        dinst.dstValid = 1'b1;
        dinst.imm = immJ;
      end
      rvPkg::opJalr: begin
        // target comes out of the alu as rs1 + imm
        if (funct3 == rvPkg::fnJalr) begin
          dinst.itype = rvPkg::Jalr;
          dinst.dstValid = 1'b1;
          dinst.imm = immI;
        end
      end
      rvPkg::opBranch: begin
        dinst.itype = rvPkg::Branch;
        dinst.imm = immB;
        case (funct3)
          rvPkg::fnBeq:  dinst.brFunc = rvPkg::Eq;
          rvPkg::fnBne:  dinst.brFunc = rvPkg::Neq;
          rvPkg::fnBlt:  dinst.brFunc = rvPkg::Lt;
          rvPkg::fnBge:  dinst.brFunc = rvPkg::Ge;
          rvPkg::fnBltu: dinst.brFunc = rvPkg::Ltu;
          rvPkg::fnBgeu: dinst.brFunc = rvPkg::Geu;
          default:       dinst.itype = rvPkg::Unsupported;
        endcase
      end
      rvPkg::opLoad: begin
        dinst.itype = rvPkg::Load;
        dinst.dstValid = 1'b1;
        dinst.imm = immI;
        case (funct3)
          rvPkg::fnLb:  dinst.memFunc = rvPkg::Lb;
          rvPkg::fnLh:  dinst.memFunc = rvPkg::Lh;
          rvPkg::fnLw:  dinst.memFunc = rvPkg::Lw;
          rvPkg::fnLbu: dinst.memFunc = rvPkg::Lbu;
          rvPkg::fnLhu: dinst.memFunc = rvPkg::Lhu;
          default:      dinst.itype = rvPkg::Unsupported;
        endcase
      end
      rvPkg::opStore: begin
        dinst.itype = rvPkg::Store;
        dinst.imm = immS;
        case (funct3)
          rvPkg::fnSb: dinst.memFunc = rvPkg::Sb;
          rvPkg::fnSh: dinst.memFunc = rvPkg::Sh;
          rvPkg::fnSw: dinst.memFunc = rvPkg::Sw;
          default:     dinst.itype = rvPkg::Unsupported;
        endcase
      end
      rvPkg::opOpImm: begin
        dinst.itype = rvPkg::OpImm;
        dinst.dstValid = 1'b1;
        dinst.imm = immI;
        case (funct3)
          rvPkg::fnAdd:  dinst.aluFunc = rvPkg::Add;
          rvPkg::fnSlt:  dinst.aluFunc = rvPkg::Slt;
          rvPkg::fnSltu: dinst.aluFunc = rvPkg::Sltu;
          rvPkg::fnXor:  dinst.aluFunc = rvPkg::Xor;
          rvPkg::fnOr:   dinst.aluFunc = rvPkg::Or;
          rvPkg::fnAnd:  dinst.aluFunc = rvPkg::And;
          // shift immediates keep funct7 in the upper imm bits
          rvPkg::fnSll: begin
            if (funct7 == rvPkg::f7Zero) dinst.aluFunc = rvPkg::Sll;
            else dinst.itype = rvPkg::Unsupported;
          end
          default: begin
            if (funct7 == rvPkg::f7Zero) dinst.aluFunc = rvPkg::Srl;
            else if (funct7 == rvPkg::f7Alt) dinst.aluFunc = rvPkg::Sra;
            else dinst.itype = rvPkg::Unsupported;
          end
        endcase
      end
      rvPkg::opOp: begin
        dinst.itype = rvPkg::Op;
        dinst.dstValid = 1'b1;
        if (funct7 == rvPkg::f7Zero) begin
          case (funct3)
            rvPkg::fnAdd:  dinst.aluFunc = rvPkg::Add;
            rvPkg::fnSll:  dinst.aluFunc = rvPkg::Sll;
            rvPkg::fnSlt:  dinst.aluFunc = rvPkg::Slt;
            rvPkg::fnSltu: dinst.aluFunc = rvPkg::Sltu;
            rvPkg::fnXor:  dinst.aluFunc = rvPkg::Xor;
            rvPkg::fnSr:   dinst.aluFunc = rvPkg::Srl;
            rvPkg::fnOr:   dinst.aluFunc = rvPkg::Or;
            default:       dinst.aluFunc = rvPkg::And;
          endcase
        end else if (funct7 == rvPkg::f7Alt && funct3 == rvPkg::fnAdd) begin
          dinst.aluFunc = rvPkg::Sub;
        end else if (funct7 == rvPkg::f7Alt && funct3 == rvPkg::fnSr) begin
          dinst.aluFunc = rvPkg::Sra;
        end else begin
          dinst.itype = rvPkg::Unsupported;
        end
      end
      default: dinst.itype = rvPkg::Unsupported;
    endcase

    // an illegal encoding never writes back
    if (dinst.itype == rvPkg::Unsupported) dinst.dstValid = 1'b0;
  end
endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input logic       clk,
  input logic       rst,
  regPortIf.regFile port
);
  // x0 has no storage
  logic [rvPkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (port.wrEn && port.wrAddr != '0) begin
      regs[port.wrAddr] <= port.wrData;
    end
  end

  // combinational reads, x0 forced to zero
  always_comb begin
    if (port.rs1Addr == '0) port.rs1Data = '0;
    else port.rs1Data = regs[port.rs1Addr];
  end

  always_comb begin
    if (port.rs2Addr == '0) port.rs2Data = '0;
    else port.rs2Data = regs[port.rs2Addr];
  end
endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rvPkg::DecodedInst      dinst,
  input  logic [rvPkg::xlen-1:0] rs1Data,
  input  logic [rvPkg::xlen-1:0] rs2Data,
  output logic [rvPkg::xlen-1:0] result,
  output logic                   branchTaken
);
  logic [rvPkg::xlen-1:0] opB;
  logic [4:0] shamt;

  // register operand only for OP, immediate for everything else
  assign opB = (dinst.itype == rvPkg::Op) ? rs2Data : dinst.imm;
  assign shamt = opB[4:0];

  always_comb begin
    case (dinst.aluFunc)
      rvPkg::Sub:  result = rs1Data - opB;
      rvPkg::And:  result = rs1Data & opB;
      rvPkg::Or:   result = rs1Data | opB;
      rvPkg::Xor:  result = rs1Data ^ opB;
      rvPkg::Slt:  result = {{(rvPkg::xlen-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
      rvPkg::Sltu: result = {{(rvPkg::xlen-1){1'b0}}, rs1Data < opB};
      rvPkg::Sll:  result = rs1Data << shamt;
      rvPkg::Srl:  result = rs1Data >> shamt;
      rvPkg::Sra:  result = $signed(rs1Data) >>> shamt;
      // also the load/store address and jalr target
      default:     result = rs1Data + opB;
    endcase
  end

  // compares rs1 and rs2 directly, only looked at for branches
  always_comb begin
    case (dinst.brFunc)
      rvPkg::Eq:  branchTaken = rs1Data == rs2Data;
      rvPkg::Neq: branchTaken = rs1Data != rs2Data;
      rvPkg::Lt:  branchTaken = $signed(rs1Data) < $signed(rs2Data);
      rvPkg::Ge:  branchTaken = $signed(rs1Data) >= $signed(rs2Data);
      rvPkg::Ltu: branchTaken = rs1Data < rs2Data;
      rvPkg::Geu: branchTaken = rs1Data >= rs2Data;
      default:    branchTaken = 1'b0;
    endcase
  end
endmodule

`default_nettype wire

// ==== logic/loadStoreUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
  input  rvPkg::MemFunc          memFunc,
  input  logic [1:0]             addrLow,
  input  logic [rvPkg::xlen-1:0] storeData,
  input  logic [rvPkg::xlen-1:0] rdData,
  output logic [3:0]             byteEn,
  output logic [rvPkg::xlen-1:0] wrData,
  output logic [rvPkg::xlen-1:0] loadData
);
  logic [7:0]  byteLane;
  logic [15:0] halfLane;

  // halfwords only look at addrLow[1], misalignment falls back to the aligned half
  always_comb begin
    case (memFunc)
      rvPkg::Sb, rvPkg::Lb, rvPkg::Lbu: byteEn = 4'b0001 << addrLow;
      rvPkg::Sh, rvPkg::Lh, rvPkg::Lhu: byteEn = addrLow[1] ? 4'b1100 : 4'b0011;
      default:                          byteEn = 4'b1111;
    endcase
  end

  // replicate into every lane, byteEn picks the one that lands
  always_comb begin
    case (memFunc)
      rvPkg::Sb: wrData = {4{storeData[7:0]}};
      rvPkg::Sh: wrData = {2{storeData[15:0]}};
      default:   wrData = storeData;
    endcase
  end

  assign byteLane = rdData[{addrLow, 3'b000} +: 8];
  assign halfLane = addrLow[1] ? rdData[31:16] : rdData[15:0];

  always_comb begin
    case (memFunc)
      rvPkg::Lb:  loadData = {{24{byteLane[7]}}, byteLane};
      rvPkg::Lbu: loadData = {24'b0, byteLane};
      rvPkg::Lh:  loadData = {{16{halfLane[15]}}, halfLane};
      rvPkg::Lhu: loadData = {16'b0, halfLane};
      default:    loadData = rdData;
    endcase
  end
endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvCore (
  input  logic                   clk,
  input  logic                   rst,
  output logic [rvPkg::xlen-1:0] imemAddr,
  input  logic [rvPkg::xlen-1:0] imemData,
  output logic [rvPkg::xlen-1:0] dmemAddr,
  output logic [rvPkg::xlen-1:0] dmemWrData,
  output logic [3:0]             dmemByteEn,
  output logic                   dmemRead,
  output logic                   dmemWrite,
  input  logic [rvPkg::xlen-1:0] dmemRdData,
  output logic                   trap
);
  logic [1:0] state;
  logic [rvPkg::xlen-1:0] pc, pcPlus4, pcPlusImm, nextPc;
  logic [rvPkg::xlen-1:0] aluResult, loadData, storeBytes, wbData;
  logic [3:0] laneEn;
  logic [1:0] addrLow;
  logic branchTaken, isMem;
  rvPkg::InstWord ir;
  rvPkg::DecodedInst dinst;

  regPortIf regPort ();

  decoder decoder_i (.inst(ir), .dinst(dinst));

  regFile regFile_i (.clk(clk), .rst(rst), .port(regPort));

  alu alu_i (
    .dinst(dinst), .rs1Data(regPort.rs1Data), .rs2Data(regPort.rs2Data),
    .result(aluResult), .branchTaken(branchTaken)
  );

  // store lanes come from the fresh address, load lanes from the registered one
  assign addrLow = (state == rvPkg::stMemory) ? dmemAddr[1:0] : aluResult[1:0];

  loadStoreUnit loadStoreUnit_i (
    .memFunc(dinst.memFunc), .addrLow(addrLow), .storeData(regPort.rs2Data),
    .rdData(dmemRdData), .byteEn(laneEn), .wrData(storeBytes), .loadData(loadData)
  );

  assign imemAddr = pc;
  assign pcPlus4 = pc + 32'd4;
  assign pcPlusImm = pc + dinst.imm;
  assign isMem = (dinst.itype == rvPkg::Load) || (dinst.itype == rvPkg::Store);

  always_comb begin
    case (dinst.itype)
      rvPkg::Lui:              wbData = dinst.imm;
      rvPkg::Auipc:            wbData = pcPlusImm;
      rvPkg::Jal, rvPkg::Jalr: wbData = pcPlus4;
      rvPkg::Load:             wbData = loadData;
      default:                 wbData = aluResult;
    endcase
  end

  always_comb begin
    case (dinst.itype)
      rvPkg::Jal:    nextPc = pcPlusImm;
      rvPkg::Jalr:   nextPc = {aluResult[rvPkg::xlen-1:1], 1'b0};
      rvPkg::Branch: nextPc = branchTaken ? pcPlusImm : pcPlus4;
      default:       nextPc = pcPlus4;
    endcase
  end

  assign regPort.rs1Addr = dinst.src1;
  assign regPort.rs2Addr = dinst.src2;
  assign regPort.wrAddr = dinst.dst;
  assign regPort.wrData = wbData;
  // loads write at the end of the memory cycle, others at the end of execute
  assign regPort.wrEn = dinst.dstValid &&
                        ((state == rvPkg::stExecute && !isMem) ||
                         (state == rvPkg::stMemory && dinst.itype == rvPkg::Load));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rvPkg::stFetch;
      pc <= '0;
      trap <= 1'b0;
      dmemRead <= 1'b0;
      dmemWrite <= 1'b0;
    end else begin
      dmemRead <= 1'b0;
      dmemWrite <= 1'b0;
      case (state)
        rvPkg::stFetch: state <= rvPkg::stExecute;
        rvPkg::stExecute: begin
          // once trapped the core parks here with pc on the bad instruction
          if (trap) begin
            state <= rvPkg::stExecute;
          end else if (dinst.itype == rvPkg::Unsupported) begin
            trap <= 1'b1;
          end else if (isMem) begin
            dmemRead <= dinst.itype == rvPkg::Load;
            dmemWrite <= dinst.itype == rvPkg::Store;
            state <= rvPkg::stMemory;
          end else begin
            pc <= nextPc;
            state <= rvPkg::stFetch;
          end
        end
        rvPkg::stMemory: begin
          pc <= pcPlus4;
          state <= rvPkg::stFetch;
        end
        default: state <= rvPkg::stFetch;
      endcase
    end
  end

  // instruction register and memory payload
  always_ff @(posedge clk) begin
    if (state == rvPkg::stFetch) ir <= imemData;
    if (state == rvPkg::stExecute) begin
      dmemAddr <= aluResult;
      dmemWrData <= storeBytes;
      dmemByteEn <= laneEn;
    end
  end
endmodule

`default_nettype wire

// ==== dv/rvCore_asserts.sv ====
`timescale 1ns/1ns

module rvCore_asserts (
  input logic        clk,
  input logic        rst,
  input logic        dmemRead,
  input logic        dmemWrite,
  input logic        trap,
  input logic [31:0] pc,
  input logic [4:0]  rs1Addr,
  input logic [31:0] rs1Data
);
  strobeExclusive: assert property (@(posedge clk) disable iff (rst)
    !(dmemRead && dmemWrite))
    else $error("dmemRead and dmemWrite high together");

  readPulse: assert property (@(posedge clk) disable iff (rst)
    dmemRead |=> !dmemRead)
    else $error("dmemRead held longer than one cycle");

  writePulse: assert property (@(posedge clk) disable iff (rst)
    dmemWrite |=> !dmemWrite)
    else $error("dmemWrite held longer than one cycle");

  // trap is sticky and freezes the pc
  trapSticky: assert property (@(posedge clk) disable iff (rst)
    trap |=> (trap && $stable(pc)))
    else $error("trap dropped or pc moved after trap");

  zeroReg: assert property (@(posedge clk) disable iff (rst)
    (rs1Addr == 5'd0) |-> (rs1Data == 32'd0))
    else $error("x0 read back nonzero");
endmodule

bind rvCore rvCore_asserts asserts_i (
  .clk(clk), .rst(rst), .dmemRead(dmemRead), .dmemWrite(dmemWrite),
  .trap(trap), .pc(imemAddr),
  .rs1Addr(regPort.rs1Addr), .rs1Data(regPort.rs1Data)
);

// ==== dv/rvCoreTb.sv ====
`timescale 1ns/1ns

module rvCoreTb;
  // program image followed by store count, store records and final pc
  localparam int progWords = 64;
  localparam int countIdx = 64;
  localparam int recordBase = 65;
  localparam int resetCycles = 16;
  // up to four visits of 64 instructions at 3 cycles each
  localparam int cycleLimit = resetCycles + progWords * 3 * 4;

  logic clk;
  logic rst;
  logic [31:0] imemAddr;
  logic [31:0] imemData;
  logic [31:0] dmemAddr;
  logic [31:0] dmemWrData;
  logic [3:0] dmemByteEn;
  logic dmemRead;
  logic dmemWrite;
  logic [31:0] dmemRdData;
  logic trap;

  logic [31:0] image [0:255];
  logic [31:0] dataMem [0:255];
  int storeCount;
  int expCount;
  int cycleCount;

  rvCore rvCore_i (
    .clk(clk), .rst(rst),
    .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemByteEn(dmemByteEn),
    .dmemRead(dmemRead), .dmemWrite(dmemWrite), .dmemRdData(dmemRdData),
    .trap(trap)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %08h, expected %08h", name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // memory model samples the strobes mid-cycle while they are stable
  always @(negedge clk) begin
    int base;
    base = recordBase + 3 * storeCount;
    if (!rst && dmemWrite) begin
      if (storeCount >= expCount) begin
        abortRun("core issued a store beyond the expected list or after the trap");
      end
      check("dmemAddr", dmemAddr, image[base]);
      check("dmemWrData", dmemWrData, image[base+1]);
      check("dmemByteEn", 32'(dmemByteEn), image[base+2]);
      for (int b = 0; b < 4; b++) begin
        if (dmemByteEn[b]) dataMem[dmemAddr[9:2]][8*b +: 8] = dmemWrData[8*b +: 8];
      end
      storeCount = storeCount + 1;
    end
    if (imemAddr < 32'd256) imemData = image[imemAddr[7:2]];
    else imemData = '0;
    // read data only while the core strobes a read
    if (dmemRead) dmemRdData = dataMem[dmemAddr[9:2]];
    else dmemRdData = '0;
  end

  initial begin
    rst = 1'b1;
    imemData = '0;
    dmemRdData = '0;
    storeCount = 0;
    for (int i = 0; i < 256; i++) begin
      image[i] = '0;
      dataMem[i] = '0;
    end
    $readmemh("dv/program_stimulus.hex", image);
    expCount = int'(image[countIdx]);

    // quiet outputs throughout reset and right after it
    repeat (resetCycles) begin
      @(negedge clk);
      check("imemAddr", imemAddr, 32'h0);
      check("dmemRead", 32'(dmemRead), 32'h0);
      check("dmemWrite", 32'(dmemWrite), 32'h0);
      check("trap", 32'(trap), 32'h0);
    end
    rst = 1'b0;
    @(negedge clk);
    check("imemAddr", imemAddr, 32'h0);
    check("dmemRead", 32'(dmemRead), 32'h0);
    check("dmemWrite", 32'(dmemWrite), 32'h0);
    check("trap", 32'(trap), 32'h0);

    while (!trap) begin
      @(negedge clk);
      if (cycleCount >= cycleLimit) begin
        abortRun("core did not reach the trap within the cycle limit");
      end
    end

    // let the frozen core sit a few cycles
    repeat (6) @(negedge clk);
    check("trap", 32'(trap), 32'h1);
    check("imemAddr", imemAddr, image[recordBase + 3 * expCount]);
    check("storeCount", 32'(storeCount), 32'(expCount));
    $display("*** TEST PASSED ***");
    $finish;
  end
endmodule

// ==== dv/program_stimulus.hex ====
// words 0-63: program; word 64: store count N
// then per line one store record: address data byteEnable; last word: final pc
10000093 // 00 addi x1,x0,256
FFB00113 // 04 addi x2,x0,-5
00300193 // 08 addi x3,x0,3
40218233 // 0c sub x4,x3,x2
0040A023 // 10 sw x4,0(x1)
403152B3 // 14 sra x5,x2,x3
0050A223 // 18 sw x5,4(x1)
00312333 // 1c slt x6,x2,x3
003133B3 // 20 sltu x7,x2,x3
0060A423 // 24 sw x6,8(x1)
0070A623 // 28 sw x7,12(x1)
12345437 // 2c lui x8,0x12345
67844413 // 30 xori x8,x8,0x678
00001497 // 34 auipc x9,1
0090A823 // 38 sw x9,16(x1)
00808A23 // 3c sb x8,20(x1)
00808AA3 // 40 sb x8,21(x1)
00208B23 // 44 sb x2,22(x1)
00508BA3 // 48 sb x5,23(x1)
00809C23 // 4c sh x8,24(x1)
00209D23 // 50 sh x2,26(x1)
01608503 // 54 lb x10,22(x1)
0160C583 // 58 lbu x11,22(x1)
01A09603 // 5c lh x12,26(x1)
0180D683 // 60 lhu x13,24(x1)
00A0AE23 // 64 sw x10,28(x1)
02B0A023 // 68 sw x11,32(x1)
02C0A223 // 6c sw x12,36(x1)
02D0A423 // 70 sw x13,40(x1)
00318463 // 74 beq x3,x3,+8 taken
0210AE23 // 78 sw x1,60(x1) skipped
00319463 // 7c bne x3,x3,+8 not taken
0230A623 // 80 sw x3,44(x1)
00314463 // 84 blt x2,x3,+8 taken
0210AE23 // 88 sw x1,60(x1) skipped
00315463 // 8c bge x2,x3,+8 not taken
0220A823 // 90 sw x2,48(x1)
00316463 // 94 bltu x2,x3,+8 not taken
00317463 // 98 bgeu x2,x3,+8 taken
0210AE23 // 9c sw x1,60(x1) skipped
0080076F // a0 jal x14,+8
0210AE23 // a4 sw x1,60(x1) skipped
02E0AA23 // a8 sw x14,52(x1)
0C000793 // ac addi x15,x0,0xc0
00178867 // b0 jalr x16,1(x15)
0210AE23 // b4 sw x1,60(x1) skipped
0210AE23 // b8 sw x1,60(x1) skipped
0210AE23 // bc sw x1,60(x1) skipped
0300AC23 // c0 sw x16,56(x1)
00300893 // c4 addi x17,x0,3
00590913 // c8 addi x18,x18,5
FFF88893 // cc addi x17,x17,-1
FE089CE3 // d0 bne x17,x0,-8
0520A023 // d4 sw x18,64(x1)
00000000 // d8 illegal encoding
@40
00000014
00000100 00000008 0000000F
00000104 FFFFFFFF 0000000F
00000108 00000001 0000000F
0000010C 00000000 0000000F
00000110 00001034 0000000F
00000114 78787878 00000001
00000115 78787878 00000002
00000116 FBFBFBFB 00000004
00000117 FFFFFFFF 00000008
00000118 56785678 00000003
0000011A FFFBFFFB 0000000C
0000011C FFFFFFFB 0000000F
00000120 000000FB 0000000F
00000124 FFFFFFFB 0000000F
00000128 00005678 0000000F
0000012C 00000003 0000000F
00000130 FFFFFFFB 0000000F
00000134 000000A4 0000000F
00000138 000000B4 0000000F
00000140 0000000F 0000000F
000000D8

// ==== vlog.f ====
logic/rvPkg.sv
logic/regPortIf.sv
logic/decoder.sv
logic/regFile.sv
logic/alu.sv
logic/loadStoreUnit.sv
logic/rvCore.sv
dv/rvCore_asserts.sv
dv/rvCoreTb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the rvCore testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module rvCoreTb -o rvCoreSim > build.log 2>&1 \
  && ./obj_dir/rvCoreSim > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
  || grep -q "TEST PASSED" sim.log && { echo "simulation passed"; exit 0; } \
  || { echo "no verdict found in sim.log"; exit 1; }
